/* filelist.f */
source/capture_pkg.sv
source/mem_bus_if.sv
source/bit_sampler.sv
source/capture_writer.sv
source/dump_reader.sv
source/capture_memory.sv
source/uart_tx.sv
source/hex_dump_top.sv
bench/clock_gen.sv
bench/hex_dump_checker.sv
bench/hex_dump_monitor.sv
bench/hex_dump_tb.sv

/* bench/hex_dump_tb.sv */
`timescale 1ns/10ps

module hex_dump_tb;

    logic   clk;
    logic   rst;
    logic   sig;
    logic   rearm;
    logic   tx;
    logic   done;
    logic   level_high;
    integer seed = 32'hd4d7ad24;
    int     density = 8;  // ones per 16 samples in the current run
    int     run_left = 0;
    int     timeouts = 0;

    clock_gen u_clock (.clk(clk), .rst(rst));

    hex_dump_top dut (
        .clk(clk), .rst(rst), .sig(sig), .rearm(rearm),
        .tx(tx), .done(done), .level_high(level_high)
    );

    hex_dump_monitor mon (
        .clk(clk), .rst(rst), .sig(sig), .rearm(rearm),
        .tx(tx), .done(done), .level_high(level_high)
    );

    // runs of biased density so level_high toggles
    initial begin
        @(posedge clk);
        forever begin
            @(negedge clk);
            if (run_left == 0) begin
                case ($unsigned($random(seed)) % 4)
                    0:       density = 1;
                    1:       density = 6;
                    2:       density = 11;
                    default: density = 15;
                endcase
                run_left = 24 + $unsigned($random(seed)) % 40;
            end
            sig = ($unsigned($random(seed)) % 16) < density;
            run_left--;
        end
    end

    task automatic wait_reset_release(inout bit ok);
        int n;
        n = 0;
        while (rst !== 1'b0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            $display("Timeout: reset never released");
            timeouts++;
            ok = 1'b0;
        end
    endtask

    task automatic wait_bytes(input int target, input int limit, inout bit ok);
        int n;
        n = 0;
        while (mon.byte_total < target && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (mon.byte_total < target) begin
            $display("Timeout: %0d of %0d bytes seen after %0d cycles",
                     mon.byte_total, target, limit);
            timeouts++;
            ok = 1'b0;
        end
    endtask

    task automatic wait_done_level(input logic level, input int limit, inout bit ok);
        int n;
        n = 0;
        while (done !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (done !== level) begin
            $display("Timeout: done did not become %b within %0d cycles", level, limit);
            timeouts++;
            ok = 1'b0;
        end
    endtask

    task automatic finish_run();
        int asserts;
        int failures;
        asserts  = dut.u_reader.reader_chk.fail_count + dut.u_memory.memory_chk.fail_count;
        failures = mon.error_count + asserts + timeouts;
        $display("Summary: %0d check errors, %0d assertion failures, %0d timeouts, %0d bytes",
                 mon.error_count, asserts, timeouts, mon.byte_total);
        if (failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    initial begin
        bit ok;
        ok    = 1'b1;
        sig   = 1'b0;
        rearm = 1'b0;
        wait_reset_release(ok);
        for (int d = 0; d < 3 && ok; d++) begin
            wait_bytes(2 * capture_pkg::CAPTURE_DEPTH * (d + 1), 6000, ok);
            if (ok) wait_done_level(1'b1, 200, ok);
            if (ok) repeat (30 + 17 * d) @(negedge clk);  // done holds while the line stays quiet
            if (ok && d < 2) begin
                rearm = 1'b1;
                wait_done_level(1'b0, 4, ok);
                rearm = 1'b0;
            end
        end
        finish_run();
    end

endmodule

/* bench/hex_dump_monitor.sv */
`timescale 1ns/10ps

module hex_dump_monitor (
    input logic clk,
    input logic rst,
    input logic sig,
    input logic rearm,
    input logic tx,
    input logic done,
    input logic level_high
);

    logic [15:0] words [$];  // model words in order of completion
    logic [15:0] cur = '0;
    logic [7:0]  rx;
    int          sample_cnt = 0;
    int          error_count = 0;
    int          byte_total = 0;
    int          dump_bytes = 0;
    int          dump_base = 0;
    bit          base_known = 1'b1;  // first dump starts at word 0
    bit          rearm_seen, rearm_edge, done_q;
    bit          level_due, level_exp, reset_checked, in_frame;

    task automatic check_byte(input logic [7:0] got);
        int         idx;
        logic [7:0] exp;
        idx = dump_base + dump_bytes / 2;
        if (!base_known || idx >= words.size()) begin
            $display("Unexpected byte %02h at %0t ns with no finished capture", got, $time);
            error_count++;
        end else begin
            exp = (dump_bytes % 2) ? words[idx][15:8] : words[idx][7:0];  // low byte first
            if (got !== exp) begin
                $display("Error at %0t ns: dump byte %0d is %02h, expected %02h (word %0d)",
                         $time, dump_bytes, got, exp, idx);
                error_count++;
            end
        end
        dump_bytes++;
        byte_total++;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (!reset_checked && (tx !== 1'b1 || done !== 1'b0 || level_high !== 1'b0)) begin
                $display("Error at %0t ns: after reset tx=%b done=%b level_high=%b",
                         $time, tx, done, level_high);
                error_count++;
            end
            reset_checked = 1'b1;
            cur = {cur[14:0], sig};  // earliest sample ends in msb
            if (sample_cnt % capture_pkg::WORD_BITS == capture_pkg::WORD_BITS - 1) begin
                words.push_back(cur);
                level_exp = ($countones(cur) >= capture_pkg::LEVEL_THRESHOLD);
                level_due = 1'b1;
                if (rearm_seen && !base_known) begin  // first word after the rearm
                    dump_base  = words.size() - 1;
                    base_known = 1'b1;
                    rearm_seen = 1'b0;
                end
            end
            sample_cnt++;
            if ((done_q && !done && !rearm_edge) || (rearm_edge && done)) begin
                $display("Error at %0t ns: done is %b, rearm in previous cycle was %b",
                         $time, done, rearm_edge);
                error_count++;
            end
            if (!done_q && done) begin
                if (dump_bytes != 2 * capture_pkg::CAPTURE_DEPTH || in_frame || tx !== 1'b1) begin
                    $display("Error at %0t ns: done rose after %0d bytes, frame open %b",
                             $time, dump_bytes, in_frame);
                    error_count++;
                end
                dump_bytes = 0;
                base_known = 1'b0;
            end
            rearm_edge = done && rearm;
            if (rearm_edge) rearm_seen = 1'b1;
            done_q = done;
        end
    end

    always @(negedge clk) begin
        if (level_due) begin
            if (level_high !== level_exp) begin
                $display("Error at %0t ns: level_high is %b, expected %b for word %0d",
                         $time, level_high, level_exp, words.size() - 1);
                error_count++;
            end
            level_due = 1'b0;
        end
    end

    // samples tx near the middle of each bit
    always begin
        @(posedge clk);
        if (reset_checked && tx === 1'b0) begin
            in_frame = 1'b1;
            if (done) begin
                $display("A frame started at %0t ns while done is high", $time);
                error_count++;
            end
            repeat (capture_pkg::BAUD_DIV / 2 - 1) @(posedge clk);
            if (tx !== 1'b0) begin
                $display("Start bit did not stay low at %0t ns", $time);
                error_count++;
            end
            for (int i = 0; i < 8; i++) begin
                repeat (capture_pkg::BAUD_DIV) @(posedge clk);
                rx[i] = tx;
            end
            repeat (capture_pkg::BAUD_DIV) @(posedge clk);
            if (tx !== 1'b1) begin
                $display("Stop bit missing at %0t ns", $time);
                error_count++;
            end
            check_byte(rx);
            in_frame = 1'b0;
        end
    end

endmodule

/* bench/hex_dump_checker.sv */
`timescale 1ns/10ps

module hex_dump_checker (
    input logic                              clk,
    input logic                              rst,
    input logic                              psel,
    input logic                              penable,
    input logic                              pready,
    input logic                              pwrite,
    input logic [capture_pkg::ADDR_BITS-1:0] paddr,
    input logic [capture_pkg::WORD_BITS-1:0] pwdata,
    input logic [1:0]                        grant,
    input logic                              tx_start,
    input logic                              tx_busy,
    input logic                              done
);

    int fail_count = 0;

    a_apb_hold: assert property (@(posedge clk) disable iff (rst)
        psel && !(penable && pready) |=> psel && $stable(paddr) && $stable(pwrite)
            && $stable(pwdata))
        else begin
            $error("bus request dropped or changed before its transfer completed");
            fail_count++;
        end

    a_apb_enable: assert property (@(posedge clk) disable iff (rst)
        psel && !penable |=> penable)
        else begin
            $error("penable did not follow the setup cycle");
            fail_count++;
        end

    a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else begin
            $error("both masters granted at once");
            fail_count++;
        end

    a_start_idle: assert property (@(posedge clk) disable iff (rst) tx_start |-> !tx_busy)
        else begin
            $error("tx_start given while the transmitter is busy");
            fail_count++;
        end

    a_done_idle: assert property (@(posedge clk) disable iff (rst) $rose(done) |-> !tx_busy)
        else begin
            $error("done rose while a frame is still on the line");
            fail_count++;
        end

endmodule

bind dump_reader hex_dump_checker reader_chk (
    .clk(clk), .rst(rst), .psel(bus.psel), .penable(bus.penable), .pready(bus.pready),
    .pwrite(bus.pwrite), .paddr(bus.paddr), .pwdata(bus.pwdata), .grant(2'b01),
    .tx_start(tx_start), .tx_busy(tx_busy), .done(done)
);

bind capture_memory hex_dump_checker memory_chk (
    .clk(clk), .rst(rst), .psel(wr_bus.psel), .penable(wr_bus.penable),
    .pready(wr_bus.pready), .pwrite(wr_bus.pwrite), .paddr(wr_bus.paddr),
    .pwdata(wr_bus.pwdata), .grant(grant), .tx_start(1'b0), .tx_busy(1'b0), .done(1'b0)
);

/* bench/clock_gen.sv */
`timescale 1ns/10ps

module clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* source/hex_dump_top.sv */
`timescale 1ns/10ps

module hex_dump_top (
    input  logic clk,
    input  logic rst,
    input  logic sig,
    input  logic rearm,
    output logic tx,
    output logic done,
    output logic level_high
);

    logic [15:0] word;
    logic        word_valid;
    logic        capture_full;
    logic        rearm_go;
    logic [7:0]  tx_data;
    logic        tx_start;
    logic        tx_busy;

    mem_bus_if wr_bus ();
    mem_bus_if rd_bus ();

    bit_sampler u_sampler (
        .clk        (clk),
        .rst        (rst),
        .sig        (sig),
        .word       (word),
        .word_valid (word_valid),
        .level_high (level_high)
    );

    capture_writer u_writer (
        .clk          (clk),
        .rst          (rst),
        .word_valid   (word_valid),
        .rearm_go     (rearm_go),
        .word         (word),
        .bus          (wr_bus.master),
        .capture_full (capture_full)
    );

    dump_reader u_reader (
        .clk          (clk),
        .rst          (rst),
        .capture_full (capture_full),
        .rearm        (rearm),
        .tx_busy      (tx_busy),
        .bus          (rd_bus.master),
        .tx_data      (tx_data),
        .tx_start     (tx_start),
        .done         (done),
        .rearm_go     (rearm_go)
    );

    capture_memory u_memory (
        .clk    (clk),
        .rst    (rst),
        .wr_bus (wr_bus.slave),
        .rd_bus (rd_bus.slave)
    );

    uart_tx u_uart (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

/* source/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       tx,
    output logic       tx_busy
);

    capture_pkg::uart_state_e                state;
    logic [capture_pkg::BAUD_CNT_BITS-1:0]   baud_cnt;
    logic [2:0]                              bit_idx;
    logic [7:0]                              shift;
    logic                                    bit_end;

    assign bit_end = (baud_cnt == capture_pkg::BAUD_LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= capture_pkg::U_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx       <= 1'b1;
            tx_busy  <= 1'b0;
        end else begin
            baud_cnt <= (state == capture_pkg::U_IDLE || bit_end) ? '0 : baud_cnt + 1'b1;
            case (state)
                capture_pkg::U_IDLE: begin
                    if (tx_start) begin
                        shift   <= tx_data;
                        tx      <= 1'b0;  // start bit
                        tx_busy <= 1'b1;
                        state   <= capture_pkg::U_START;
                    end
                end
                capture_pkg::U_START: begin
                    if (bit_end) begin
                        tx      <= shift[0];  // lsb first
                        shift   <= shift >> 1;
                        bit_idx <= '0;
                        state   <= capture_pkg::U_DATA;
                    end
                end
                capture_pkg::U_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            tx    <= 1'b1;  // stop bit
                            state <= capture_pkg::U_STOP;
                        end else begin
                            tx      <= shift[0];
                            shift   <= shift >> 1;
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        tx_busy <= 1'b0;
                        state   <= capture_pkg::U_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

/* source/capture_memory.sv */
`timescale 1ns/10ps

module capture_memory (
    input  logic      clk,
    input  logic      rst,
    mem_bus_if.slave  wr_bus,
    mem_bus_if.slave  rd_bus
);

    logic [capture_pkg::WORD_BITS-1:0]  mem [capture_pkg::CAPTURE_DEPTH];
    logic [1:0]                         grant;  // bit 0 writer, bit 1 reader
    logic                               wr_xfer;
    logic                               rd_xfer;
    capture_pkg::bus_cmd_e              acc_cmd;
    logic [capture_pkg::ADDR_BITS-1:0]  acc_addr;
    logic [capture_pkg::WORD_BITS-1:0]  acc_wdata;
    logic [capture_pkg::WORD_BITS-1:0]  rd_word;

    assign wr_bus.pready = grant[0] && wr_bus.penable;
    assign rd_bus.pready = grant[1] && rd_bus.penable;

    assign wr_xfer = wr_bus.psel && wr_bus.penable && wr_bus.pready;
    assign rd_xfer = rd_bus.psel && rd_bus.penable && rd_bus.pready;

    // granted master drives the array
    always_comb begin
        if (grant[1]) begin
            acc_cmd   = rd_bus.pwrite;
            acc_addr  = rd_bus.paddr;
            acc_wdata = rd_bus.pwdata;
        end else begin
            acc_cmd   = wr_bus.pwrite;
            acc_addr  = wr_bus.paddr;
            acc_wdata = wr_bus.pwdata;
        end
    end

    assign rd_word = mem[acc_addr];  // async read, valid in the completing cycle

    assign wr_bus.prdata = grant[0] ? rd_word : '0;
    assign rd_bus.prdata = grant[1] ? rd_word : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= 2'b00;
        end else if (wr_xfer || rd_xfer) begin
            grant <= 2'b00;
        end else if (grant == 2'b00) begin
            if (wr_bus.psel) begin
                grant <= 2'b01;  // writer wins ties
            end else if (rd_bus.psel) begin
                grant <= 2'b10;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((wr_xfer || rd_xfer) && acc_cmd == capture_pkg::CMD_WRITE) begin
            mem[acc_addr] <= acc_wdata;
        end
    end

endmodule

/* source/dump_reader.sv */
`timescale 1ns/10ps

module dump_reader (
    input  logic        clk,
    input  logic        rst,
    input  logic        capture_full,
    input  logic        rearm,
    input  logic        tx_busy,
    mem_bus_if.master   bus,
    output logic [7:0]  tx_data,
    output logic        tx_start,
    output logic        done,
    output logic        rearm_go
);

    capture_pkg::reader_state_e         state;
    logic [capture_pkg::ADDR_BITS-1:0]  addr;
    logic [capture_pkg::WORD_BITS-1:0]  word_q;
    logic                               tx_free;

    // busy only rises the cycle after a start, so a pending start counts as busy
    assign tx_free = !tx_busy && !tx_start;

    assign bus.psel    = (state == capture_pkg::R_SETUP) || (state == capture_pkg::R_ACCESS);
    assign bus.penable = (state == capture_pkg::R_ACCESS);
    assign bus.pwrite  = capture_pkg::CMD_READ;
    assign bus.paddr   = addr;
    assign bus.pwdata  = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= capture_pkg::R_IDLE;
            addr     <= '0;
            tx_start <= 1'b0;
            done     <= 1'b0;
            rearm_go <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            rearm_go <= 1'b0;
            case (state)
                capture_pkg::R_IDLE: begin
                    // capture_full is still up during the rearm_go cycle
                    if (capture_full && !rearm_go) state <= capture_pkg::R_SETUP;
                end
                capture_pkg::R_SETUP:  state <= capture_pkg::R_ACCESS;
                capture_pkg::R_ACCESS: if (bus.pready) state <= capture_pkg::R_SEND_LO;
                capture_pkg::R_SEND_LO: begin
                    if (tx_free) begin
                        tx_start <= 1'b1;
                        state    <= capture_pkg::R_SEND_HI;
                    end
                end
                capture_pkg::R_SEND_HI: begin
                    if (tx_free) begin
                        tx_start <= 1'b1;
                        addr     <= addr + 1'b1;  // wraps to 0 after the last word
                        state    <= (addr == capture_pkg::LAST_ADDR) ? capture_pkg::R_DONE
                                                                     : capture_pkg::R_SETUP;
                    end
                end
                default: begin
                    if (done && rearm) begin
                        done     <= 1'b0;
                        rearm_go <= 1'b1;
                        state    <= capture_pkg::R_IDLE;
                    end else if (tx_free) begin
                        done <= 1'b1;  // last stop bit is out
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == capture_pkg::R_ACCESS && bus.pready) word_q <= bus.prdata;
        if (state == capture_pkg::R_SEND_LO && tx_free) tx_data <= word_q[7:0];
        if (state == capture_pkg::R_SEND_HI && tx_free) tx_data <= word_q[15:8];
    end

endmodule

/* source/capture_writer.sv */
`timescale 1ns/10ps

module capture_writer (
    input  logic             clk,
    input  logic             rst,
    input  logic             word_valid,
    input  logic             rearm_go,
    input  logic [15:0]      word,
    mem_bus_if.master        bus,
    output logic             capture_full
);

    capture_pkg::writer_state_e         state;
    logic [capture_pkg::ADDR_BITS-1:0]  addr;
    logic [capture_pkg::WORD_BITS-1:0]  data;

    assign bus.psel    = (state == capture_pkg::W_SETUP) || (state == capture_pkg::W_ACCESS);
    assign bus.penable = (state == capture_pkg::W_ACCESS);
    assign bus.pwrite  = capture_pkg::CMD_WRITE;
    assign bus.paddr   = addr;
    assign bus.pwdata  = data;
    assign capture_full = (state == capture_pkg::W_FULL);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= capture_pkg::W_IDLE;
            addr  <= '0;
        end else begin
            case (state)
                capture_pkg::W_IDLE:   if (word_valid) state <= capture_pkg::W_SETUP;
                capture_pkg::W_SETUP:  state <= capture_pkg::W_ACCESS;
                capture_pkg::W_ACCESS: begin
                    if (bus.pready) begin  // write lands this cycle
                        addr  <= addr + 1'b1;
                        state <= (addr == capture_pkg::LAST_ADDR) ? capture_pkg::W_FULL
                                                                  : capture_pkg::W_IDLE;
                    end
                end
                default: begin
                    if (rearm_go) begin  // words arriving while full are dropped
                        addr  <= '0;
                        state <= capture_pkg::W_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == capture_pkg::W_IDLE && word_valid) data <= word;
    end

endmodule

/* source/bit_sampler.sv */
`timescale 1ns/10ps

module bit_sampler (
    input  logic        clk,
    input  logic        rst,
    input  logic        sig,
    output logic [15:0] word,
    output logic        word_valid,
    output logic        level_high
);

    logic [capture_pkg::SAMPLE_CNT_BITS-1:0] cnt;
    logic [capture_pkg::WORD_BITS-1:0]       shift;
    logic [capture_pkg::WORD_BITS-1:0]       next_shift;
    logic [capture_pkg::ONES_BITS-1:0]       ones;

    assign next_shift = {shift[capture_pkg::WORD_BITS-2:0], sig};  // oldest sample ends up in msb

    always_comb begin
        ones = '0;
        for (int i = 0; i < capture_pkg::WORD_BITS; i++) begin
            ones = ones + next_shift[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt        <= '0;
            word_valid <= 1'b0;
            level_high <= 1'b0;
        end else begin
            cnt        <= cnt + 1'b1;
            word_valid <= (cnt == '1);
            if (cnt == '1) begin
                level_high <= (ones >= capture_pkg::LEVEL_THRESHOLD);
            end
        end
    end

    always_ff @(posedge clk) begin
        shift <= next_shift;
        if (cnt == '1) begin
            word <= next_shift;  // 16th sample completes the word
        end
    end

endmodule

/* source/mem_bus_if.sv */
`timescale 1ns/10ps

interface mem_bus_if;

    logic                                psel;
    logic                                penable;
    capture_pkg::bus_cmd_e               pwrite;
    logic [capture_pkg::ADDR_BITS-1:0]   paddr;
    logic [capture_pkg::WORD_BITS-1:0]   pwdata;
    logic [capture_pkg::WORD_BITS-1:0]   prdata;
    logic                                pready;  // low while another master holds the grant

    modport master (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready
    );

    modport slave (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready
    );

endinterface

/* source/capture_pkg.sv */
package capture_pkg;

    localparam int WORD_BITS     = 16;
    localparam int CAPTURE_DEPTH = 16;
    localparam int ADDR_BITS     = 4;
    localparam logic [ADDR_BITS-1:0] LAST_ADDR = ADDR_BITS'(CAPTURE_DEPTH - 1);

    localparam int SAMPLE_CNT_BITS = $clog2(WORD_BITS);
    localparam int ONES_BITS       = SAMPLE_CNT_BITS + 1;
    localparam logic [ONES_BITS-1:0] LEVEL_THRESHOLD = 12;  // ones per word for level_high

    localparam int BAUD_DIV      = 8;  // clocks per uart bit
    localparam int BAUD_CNT_BITS = $clog2(BAUD_DIV);
    localparam logic [BAUD_CNT_BITS-1:0] BAUD_LAST = BAUD_CNT_BITS'(BAUD_DIV - 1);

    typedef enum logic {
        CMD_READ  = 1'b0,
        CMD_WRITE = 1'b1
    } bus_cmd_e;

    typedef enum logic [1:0] {W_IDLE, W_SETUP, W_ACCESS, W_FULL} writer_state_e;

    typedef enum logic [2:0] {
        R_IDLE, R_SETUP, R_ACCESS, R_SEND_LO, R_SEND_HI, R_DONE
    } reader_state_e;

    typedef enum logic [1:0] {U_IDLE, U_START, U_DATA, U_STOP} uart_state_e;

endpackage
